// ==== isaPkg.sv ====
package isaPkg;

    // Instruction field positions
    localparam int OP_HI    = 31;
    localparam int OP_LO    = 26;
    localparam int RS_HI    = 25;
    localparam int RS_LO    = 21;
    localparam int RT_HI    = 20;
    localparam int RT_LO    = 16;
    localparam int RD_HI    = 15;
    localparam int RD_LO    = 11;
    localparam int IMM_HI   = 15;
    localparam int IMM_LO   = 0;
    localparam int FUNCT_HI = 5;
    localparam int FUNCT_LO = 0;

    localparam int REG_ADDR_W = 5;
    localparam logic [REG_ADDR_W-1:0] REG_ZERO = '0;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // R-type funct codes
    typedef enum logic [5:0] {
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } functE;

endpackage

// ==== corePkg.sv ====
package corePkg;

    localparam int XLEN = 32;

    // First fetch after reset
    localparam logic [XLEN-1:0] RESET_PC   = 32'h0040_0000;
    localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_LT
    } aluOpE;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_EXMEM,
        FWD_FROM_MEMWB
    } fwdSelE;

endpackage

// ==== fetchStage.sv ====
module fetchStage (
    input  logic                     iClk,
    input  logic                     iRst_n,
    input  logic                     stallFetch,
    input  logic                     squashFetch,
    input  logic                     takenBranch,
    input  logic [corePkg::XLEN-1:0] branchTarget,
    input  logic [corePkg::XLEN-1:0] inst,
    output logic [corePkg::XLEN-1:0] instAddr,
    output logic [corePkg::XLEN-1:0] ifidInst,
    output logic [corePkg::XLEN-1:0] ifidPcPlus4
);
    import corePkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] fetchPlus4;

    // Registered redirect from EX/MEM overrides the PC
    assign instAddr   = takenBranch ? branchTarget : pc;
    assign fetchPlus4 = instAddr + INST_BYTES;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            pc       <= RESET_PC;
            ifidInst <= '0;
        end else if (squashFetch) begin
            // Word in this slot is dropped, target fetched again next cycle
            pc       <= instAddr;
            ifidInst <= '0;
        end else if (!stallFetch) begin
            pc       <= fetchPlus4;
            ifidInst <= inst;
        end
    end

    always_ff @(posedge iClk) begin
        if (!stallFetch) begin
            ifidPcPlus4 <= fetchPlus4;
        end
    end

endmodule

// ==== regFile.sv ====
module regFile (
    input  logic                          iClk,
    input  logic                          iRst_n,
    input  logic [isaPkg::REG_ADDR_W-1:0] rdIdx0,
    input  logic [isaPkg::REG_ADDR_W-1:0] rdIdx1,
    output logic [corePkg::XLEN-1:0]      rdData0,
    output logic [corePkg::XLEN-1:0]      rdData1,
    input  logic [isaPkg::REG_ADDR_W-1:0] wrIdx,
    input  logic [corePkg::XLEN-1:0]      wrData,
    input  logic                          wrEn
);
    import isaPkg::*;
    import corePkg::*;

    logic [XLEN-1:0] regs [1 << REG_ADDR_W];

    assign rdData0 = regs[rdIdx0];
    assign rdData1 = regs[rdIdx1];

    // Register zero stays at its reset value
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != REG_ZERO) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

// ==== decodeCtrl.sv ====
module decodeCtrl (
    input  logic [corePkg::XLEN-1:0]      inst,
    output logic [isaPkg::REG_ADDR_W-1:0] rsIdx,
    output logic [isaPkg::REG_ADDR_W-1:0] rtIdx,
    output logic                          regDst,
    output logic                          regWrite,
    output logic                          aluSrc,
    output logic                          memToReg,
    output logic                          memRead,
    output logic                          memWrite,
    output logic                          branch,
    output logic                          branchEq,
    output corePkg::aluOpE                aluOp,
    output logic                          aluSigned
);
    import isaPkg::*;
    import corePkg::*;

    opcodeE opcode;
    functE  funct;

    assign opcode = opcodeE'(inst[OP_HI:OP_LO]);
    assign funct  = functE'(inst[FUNCT_HI:FUNCT_LO]);
    assign rsIdx  = inst[RS_HI:RS_LO];
    assign rtIdx  = inst[RT_HI:RT_LO];

    always_comb begin
        // Defaults give a no-op
        regDst    = 1'b0;
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memToReg  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        branchEq  = 1'b0;
        aluOp     = ALU_ADD;
        aluSigned = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: aluOp = ALU_ADD;
                    FN_SUB, FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:          aluOp = ALU_AND;
                    FN_OR:           aluOp = ALU_OR;
                    FN_XOR:          aluOp = ALU_XOR;
                    FN_NOR:          aluOp = ALU_NOR;
                    FN_SLT: begin
                        aluOp     = ALU_LT;
                        aluSigned = 1'b1;
                    end
                    default:         regWrite = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OP_ANDI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = ALU_AND;
            end
            OP_ORI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = ALU_OR;
            end
            OP_SLTI, OP_SLTIU: begin
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                aluOp     = ALU_LT;
                aluSigned = (opcode == OP_SLTI);
            end
            OP_LW: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // Compare by subtraction, zero flag decides
                branch   = 1'b1;
                branchEq = (opcode == OP_BEQ);
                aluOp    = ALU_SUB;
            end
            default: ;
        endcase
    end

endmodule

// ==== aluUnit.sv ====
module aluUnit (
    input  logic [corePkg::XLEN-1:0] a,
    input  logic [corePkg::XLEN-1:0] b,
    input  corePkg::aluOpE           op,
    input  logic                     signedCmp,
    output logic [corePkg::XLEN-1:0] result,
    output logic                     zero
);
    import corePkg::*;

    logic lessThan;

    assign lessThan = signedCmp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            ALU_LT:  result = {{(XLEN - 1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
    input  logic                          takenBranch,
    input  logic                          idexMemRead,
    input  logic [isaPkg::REG_ADDR_W-1:0] idexRt,
    input  logic [isaPkg::REG_ADDR_W-1:0] ifidRs,
    input  logic [isaPkg::REG_ADDR_W-1:0] ifidRt,
    output logic                          stallFetch,
    output logic                          squashFetch,
    output logic                          squashDecode
);
    import isaPkg::*;

    logic loadUse;

    // Load in execute feeding the instruction in decode
    assign loadUse = idexMemRead && (idexRt != REG_ZERO) &&
                     (idexRt == ifidRs || idexRt == ifidRt);

    // Redirect wins over the load-use stall
    assign squashFetch  = takenBranch;
    assign stallFetch   = !takenBranch && loadUse;
    assign squashDecode = takenBranch || loadUse;

endmodule

// ==== execStage.sv ====
module execStage (
    input  logic                          iClk,
    input  logic                          iRst_n,
    input  logic                          squashDecode,
    input  logic [corePkg::XLEN-1:0]      ifidInst,
    input  logic [corePkg::XLEN-1:0]      ifidPcPlus4,
    input  logic [corePkg::XLEN-1:0]      rdData0,
    input  logic [corePkg::XLEN-1:0]      rdData1,
    input  logic                          regDst,
    input  logic                          regWrite,
    input  logic                          aluSrc,
    input  logic                          memToReg,
    input  logic                          memRead,
    input  logic                          memWrite,
    input  logic                          branch,
    input  logic                          branchEq,
    input  corePkg::aluOpE                aluOp,
    input  logic                          aluSigned,
    input  logic                          memWbRegWrite,
    input  logic [isaPkg::REG_ADDR_W-1:0] memWbIdx,
    input  logic [corePkg::XLEN-1:0]      memWbData,
    output logic                          takenBranch,
    output logic [corePkg::XLEN-1:0]      branchTarget,
    output logic                          idexMemRead,
    output logic [isaPkg::REG_ADDR_W-1:0] idexRt,
    output logic [corePkg::XLEN-1:0]      exmemAddr,
    output logic [corePkg::XLEN-1:0]      exmemWrData,
    output logic                          exmemMemRead,
    output logic                          exmemMemWrite,
    output logic                          exmemMemToReg,
    output logic                          exmemRegWrite,
    output logic [isaPkg::REG_ADDR_W-1:0] exmemIdx
);
    import isaPkg::*;
    import corePkg::*;

    logic                  exFwdOk;
    logic                  wbFwdOk;
    logic [REG_ADDR_W-1:0] ifidRs;
    logic [REG_ADDR_W-1:0] ifidRt;
    logic [XLEN-1:0]       idRsData;
    logic [XLEN-1:0]       idRtData;
    logic                  idexRegDst;
    logic                  idexRegWrite;
    logic                  idexAluSrc;
    logic                  idexMemToReg;
    logic                  idexMemWrite;
    logic                  idexBranch;
    logic                  idexBranchEq;
    aluOpE                 idexAluOp;
    logic                  idexAluSigned;
    logic [REG_ADDR_W-1:0] idexRs;
    logic [REG_ADDR_W-1:0] idexRd;
    logic [IMM_HI:IMM_LO]  idexImm;
    logic [XLEN-1:0]       idexPcPlus4;
    logic [XLEN-1:0]       idexRsData;
    logic [XLEN-1:0]       idexRtData;
    fwdSelE                fwdA;
    fwdSelE                fwdB;
    logic [XLEN-1:0]       opA;
    logic [XLEN-1:0]       rtVal;
    logic [XLEN-1:0]       aluB;
    logic [XLEN-1:0]       aluResult;
    logic                  aluZero;
    logic                  exTaken;

    assign ifidRs  = ifidInst[RS_HI:RS_LO];
    assign ifidRt  = ifidInst[RT_HI:RT_LO];
    assign exFwdOk = exmemRegWrite && exmemIdx != REG_ZERO;
    assign wbFwdOk = memWbRegWrite && memWbIdx != REG_ZERO;

    // Writeback of this cycle is not yet in the register file
    assign idRsData = (wbFwdOk && memWbIdx == ifidRs) ? memWbData : rdData0;
    assign idRtData = (wbFwdOk && memWbIdx == ifidRt) ? memWbData : rdData1;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            idexRegDst    <= 1'b0;
            idexRegWrite  <= 1'b0;
            idexAluSrc    <= 1'b0;
            idexMemToReg  <= 1'b0;
            idexMemRead   <= 1'b0;
            idexMemWrite  <= 1'b0;
            idexBranch    <= 1'b0;
            idexBranchEq  <= 1'b0;
            idexAluOp     <= ALU_ADD;
            idexAluSigned <= 1'b0;
        end else begin
            // Squash leaves a bubble with no side effects
            idexRegWrite  <= regWrite && !squashDecode;
            idexMemRead   <= memRead && !squashDecode;
            idexMemWrite  <= memWrite && !squashDecode;
            idexBranch    <= branch && !squashDecode;
            idexRegDst    <= regDst;
            idexAluSrc    <= aluSrc;
            idexMemToReg  <= memToReg;
            idexBranchEq  <= branchEq;
            idexAluOp     <= aluOp;
            idexAluSigned <= aluSigned;
        end
    end

    always_ff @(posedge iClk) begin
        idexRs      <= ifidRs;
        idexRt      <= ifidRt;
        idexRd      <= ifidInst[RD_HI:RD_LO];
        idexImm     <= ifidInst[IMM_HI:IMM_LO];
        idexPcPlus4 <= ifidPcPlus4;
        idexRsData  <= idRsData;
        idexRtData  <= idRtData;
    end

    // EX/MEM first, then MEM/WB
    assign fwdA = (exFwdOk && exmemIdx == idexRs) ? FWD_FROM_EXMEM :
                  (wbFwdOk && memWbIdx == idexRs) ? FWD_FROM_MEMWB : FWD_NONE;
    assign fwdB = (exFwdOk && exmemIdx == idexRt) ? FWD_FROM_EXMEM :
                  (wbFwdOk && memWbIdx == idexRt) ? FWD_FROM_MEMWB : FWD_NONE;

    always_comb begin
        case (fwdA)
            FWD_FROM_EXMEM: opA = exmemAddr;
            FWD_FROM_MEMWB: opA = memWbData;
            default:        opA = idexRsData;
        endcase
        case (fwdB)
            FWD_FROM_EXMEM: rtVal = exmemAddr;
            FWD_FROM_MEMWB: rtVal = memWbData;
            default:        rtVal = idexRtData;
        endcase
    end

    assign aluB = idexAluSrc ? {{(XLEN - 16){idexImm[IMM_HI]}}, idexImm} : rtVal;

    aluUnit alu (
        .a         (opA),
        .b         (aluB),
        .op        (idexAluOp),
        .signedCmp (idexAluSigned),
        .result    (aluResult),
        .zero      (aluZero)
    );

    assign exTaken = idexBranch && (idexBranchEq == aluZero);

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            takenBranch   <= 1'b0;
            exmemMemRead  <= 1'b0;
            exmemMemWrite <= 1'b0;
            exmemMemToReg <= 1'b0;
            exmemRegWrite <= 1'b0;
        end else begin
            // The slot right after a taken branch is cleared here
            takenBranch   <= exTaken && !takenBranch;
            exmemMemRead  <= idexMemRead && !takenBranch;
            exmemMemWrite <= idexMemWrite && !takenBranch;
            exmemRegWrite <= idexRegWrite && !takenBranch;
            exmemMemToReg <= idexMemToReg;
        end
    end

    always_ff @(posedge iClk) begin
        exmemAddr    <= aluResult;
        exmemWrData  <= rtVal;
        exmemIdx     <= idexRegDst ? idexRd : idexRt;
        branchTarget <= idexPcPlus4 + {{(XLEN - 18){idexImm[IMM_HI]}}, idexImm, 2'b00};
    end

endmodule

// ==== memWbStage.sv ====
module memWbStage (
    input  logic                          iClk,
    input  logic                          iRst_n,
    input  logic [corePkg::XLEN-1:0]      exmemAddr,
    input  logic [corePkg::XLEN-1:0]      exmemWrData,
    input  logic                          exmemMemRead,
    input  logic                          exmemMemWrite,
    input  logic                          exmemMemToReg,
    input  logic                          exmemRegWrite,
    input  logic [isaPkg::REG_ADDR_W-1:0] exmemIdx,
    input  logic [corePkg::XLEN-1:0]      memRdData,
    output logic [corePkg::XLEN-1:0]      memAddr,
    output logic [corePkg::XLEN-1:0]      memWrData,
    output logic                          memWrite,
    output logic                          memRead,
    output logic                          memWbRegWrite,
    output logic [isaPkg::REG_ADDR_W-1:0] memWbIdx,
    output logic [corePkg::XLEN-1:0]      memWbData
);

    // Strobes last exactly the one cycle the access sits in EX/MEM
    assign memAddr   = exmemAddr;
    assign memWrData = exmemWrData;
    assign memWrite  = exmemMemWrite;
    assign memRead   = exmemMemRead;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            memWbRegWrite <= 1'b0;
        end else begin
            memWbRegWrite <= exmemRegWrite;
        end
    end

    always_ff @(posedge iClk) begin
        memWbIdx  <= exmemIdx;
        memWbData <= exmemMemToReg ? memRdData : exmemAddr;
    end

endmodule

// ==== pipelineCore.sv ====
module pipelineCore (
    input  logic                     iClk,
    input  logic                     iRst_n,
    output logic [corePkg::XLEN-1:0] instAddr,
    input  logic [corePkg::XLEN-1:0] inst,
    output logic [corePkg::XLEN-1:0] memAddr,
    output logic [corePkg::XLEN-1:0] memWrData,
    output logic                     memWrite,
    output logic                     memRead,
    input  logic [corePkg::XLEN-1:0] memRdData
);
    import isaPkg::*;
    import corePkg::*;

    logic [XLEN-1:0]       ifidInst;
    logic [XLEN-1:0]       ifidPcPlus4;
    logic                  stallFetch;
    logic                  squashFetch;
    logic                  squashDecode;
    logic                  takenBranch;
    logic [XLEN-1:0]       branchTarget;
    logic [REG_ADDR_W-1:0] rsIdx;
    logic [REG_ADDR_W-1:0] rtIdx;
    logic [XLEN-1:0]       rdData0;
    logic [XLEN-1:0]       rdData1;
    logic                  regDst;
    logic                  regWrite;
    logic                  aluSrc;
    logic                  memToReg;
    logic                  decMemRead;
    logic                  decMemWrite;
    logic                  branch;
    logic                  branchEq;
    aluOpE                 aluOp;
    logic                  aluSigned;
    logic                  idexMemRead;
    logic [REG_ADDR_W-1:0] idexRt;
    logic [XLEN-1:0]       exmemAddr;
    logic [XLEN-1:0]       exmemWrData;
    logic                  exmemMemRead;
    logic                  exmemMemWrite;
    logic                  exmemMemToReg;
    logic                  exmemRegWrite;
    logic [REG_ADDR_W-1:0] exmemIdx;
    logic                  memWbRegWrite;
    logic [REG_ADDR_W-1:0] memWbIdx;
    logic [XLEN-1:0]       memWbData;

    fetchStage fetch (
        .iClk         (iClk),
        .iRst_n       (iRst_n),
        .stallFetch   (stallFetch),
        .squashFetch  (squashFetch),
        .takenBranch  (takenBranch),
        .branchTarget (branchTarget),
        .inst         (inst),
        .instAddr     (instAddr),
        .ifidInst     (ifidInst),
        .ifidPcPlus4  (ifidPcPlus4)
    );

    regFile regs (
        .iClk    (iClk),
        .iRst_n  (iRst_n),
        .rdIdx0  (rsIdx),
        .rdIdx1  (rtIdx),
        .rdData0 (rdData0),
        .rdData1 (rdData1),
        .wrIdx   (memWbIdx),
        .wrData  (memWbData),
        .wrEn    (memWbRegWrite)
    );

    decodeCtrl decode (
        .inst      (ifidInst),
        .rsIdx     (rsIdx),
        .rtIdx     (rtIdx),
        .regDst    (regDst),
        .regWrite  (regWrite),
        .aluSrc    (aluSrc),
        .memToReg  (memToReg),
        .memRead   (decMemRead),
        .memWrite  (decMemWrite),
        .branch    (branch),
        .branchEq  (branchEq),
        .aluOp     (aluOp),
        .aluSigned (aluSigned)
    );

    hazardUnit hazard (
        .takenBranch  (takenBranch),
        .idexMemRead  (idexMemRead),
        .idexRt       (idexRt),
        .ifidRs       (rsIdx),
        .ifidRt       (rtIdx),
        .stallFetch   (stallFetch),
        .squashFetch  (squashFetch),
        .squashDecode (squashDecode)
    );

    execStage exec (
        .iClk          (iClk),
        .iRst_n        (iRst_n),
        .squashDecode  (squashDecode),
        .ifidInst      (ifidInst),
        .ifidPcPlus4   (ifidPcPlus4),
        .rdData0       (rdData0),
        .rdData1       (rdData1),
        .regDst        (regDst),
        .regWrite      (regWrite),
        .aluSrc        (aluSrc),
        .memToReg      (memToReg),
        .memRead       (decMemRead),
        .memWrite      (decMemWrite),
        .branch        (branch),
        .branchEq      (branchEq),
        .aluOp         (aluOp),
        .aluSigned     (aluSigned),
        .memWbRegWrite (memWbRegWrite),
        .memWbIdx      (memWbIdx),
        .memWbData     (memWbData),
        .takenBranch   (takenBranch),
        .branchTarget  (branchTarget),
        .idexMemRead   (idexMemRead),
        .idexRt        (idexRt),
        .exmemAddr     (exmemAddr),
        .exmemWrData   (exmemWrData),
        .exmemMemRead  (exmemMemRead),
        .exmemMemWrite (exmemMemWrite),
        .exmemMemToReg (exmemMemToReg),
        .exmemRegWrite (exmemRegWrite),
        .exmemIdx      (exmemIdx)
    );

    memWbStage memWb (
        .iClk          (iClk),
        .iRst_n        (iRst_n),
        .exmemAddr     (exmemAddr),
        .exmemWrData   (exmemWrData),
        .exmemMemRead  (exmemMemRead),
        .exmemMemWrite (exmemMemWrite),
        .exmemMemToReg (exmemMemToReg),
        .exmemRegWrite (exmemRegWrite),
        .exmemIdx      (exmemIdx),
        .memRdData     (memRdData),
        .memAddr       (memAddr),
        .memWrData     (memWrData),
        .memWrite      (memWrite),
        .memRead       (memRead),
        .memWbRegWrite (memWbRegWrite),
        .memWbIdx      (memWbIdx),
        .memWbData     (memWbData)
    );

endmodule

// ==== tbProgram.svh ====
function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [5:0] fnCode(input int i);
    case (i)
        0:       return FN_ADD;
        1:       return FN_ADDU;
        2:       return FN_SUB;
        3:       return FN_SUBU;
        4:       return FN_AND;
        5:       return FN_OR;
        6:       return FN_XOR;
        7:       return FN_NOR;
        default: return FN_SLT;
    endcase
endfunction

function automatic logic [5:0] opCode(input int i);
    case (i)
        0:       return OP_ADDI;
        1:       return OP_ADDIU;
        2:       return OP_ANDI;
        3:       return OP_ORI;
        4:       return OP_SLTI;
        default: return OP_SLTIU;
    endcase
endfunction

task automatic emit(input logic [31:0] w);
    imem[8'(progLen)] = w;
    progLen++;
endtask

// Each observed result gets its own store word from 0x100 up
task automatic storeReg(input logic [4:0] rt);
    emit(encI(OP_SW, rt, 5'd0, 16'(16'h0100 + 4 * storeIdx)));
    storeIdx++;
endtask

task automatic buildProgram();
    logic [31:0] rnd;
    logic [4:0]  d;
    logic [4:0]  s;
    logic [4:0]  t;
    int          sel;
    storeIdx = 0;
    for (int k = 1; k <= 8; k++) begin
        rnd = nextRand();
        emit(encI(OP_ADDIU, 5'(k), 5'd0, rnd[15:0]));
    end
    // Every R-type and I-type op once, result stored straight away
    for (int k = 0; k < 15; k++) begin
        d   = 5'(16 + k);
        s   = 5'(1 + nextRand() % 8);
        t   = 5'(1 + nextRand() % 8);
        rnd = nextRand();
        if (k < 9) emit(encR(fnCode(k), d, s, t));
        else emit(encI(opCode(k - 9), d, s, rnd[15:0]));
        storeReg(d);
    end
    // Dependent chain over both forwarding distances
    emit(encR(FN_ADD, 5'd9, 5'd1, 5'd2));
    emit(encR(FN_SUB, 5'd10, 5'd9, 5'd3));
    emit(encR(FN_XOR, 5'd11, 5'd9, 5'd10));
    storeReg(5'd11);
    // Load followed at once by its consumer
    emit(encI(OP_LW, 5'd12, 5'd0, 16'(4 * (nextRand() % 64))));
    emit(encR(FN_ADDU, 5'd13, 5'd12, 5'd1));
    storeReg(5'd13);
    // Taken branches with stores in both squashed slots
    emit(encI(OP_BEQ, 5'd1, 5'd1, 16'd2));
    storeReg(5'd1);
    storeReg(5'd2);
    emit(encI(OP_BNE, 5'd3, 5'd2, 16'd2));
    storeReg(5'd3);
    storeReg(5'd4);
    emit(encI(OP_BEQ, 5'd3, 5'd2, 16'd1));
    storeReg(5'd2);
    emit(encI(OP_BNE, 5'd4, 5'd4, 16'd1));
    storeReg(5'd4);
    emit(encI(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
    storeReg(5'd0);
    for (int k = 0; k < 16; k++) begin
        sel = nextRand() % 15;
        d   = 5'(9 + nextRand() % 7);
        s   = 5'(nextRand() % 16);
        t   = 5'(nextRand() % 16);
        rnd = nextRand();
        if (sel < 9) emit(encR(fnCode(sel), d, s, t));
        else emit(encI(opCode(sel - 9), d, s, rnd[15:0]));
        if (k % 2 == 1) storeReg(d);
    end
    for (int k = 9; k < 16; k++) begin
        storeReg(5'(k));
    end
    emit(encI(OP_SW, 5'd1, 5'd0, SENTINEL[15:0]));
endtask

// ISA-level interpreter, logs expected loads and stores in order
function automatic void runReference();
    logic [31:0] r [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] addr;
    logic [5:0]  op;
    logic [4:0]  rt;
    int          steps;
    bit          done;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) refMem[i] = dmem[i];
    pc    = RESET_PC;
    steps = 0;
    done  = 0;
    while (!done && steps < 1000) begin
        ins  = (pc[31:10] == RESET_PC[31:10]) ? imem[pc[9:2]] : '0;
        op   = ins[31:26];
        rt   = ins[20:16];
        a    = r[ins[25:21]];
        b    = r[rt];
        se   = {{16{ins[15]}}, ins[15:0]};
        addr = a + se;
        pc   = pc + 32'd4;
        case (op)
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADD, FN_ADDU: r[ins[15:11]] = a + b;
                    FN_SUB, FN_SUBU: r[ins[15:11]] = a - b;
                    FN_AND: r[ins[15:11]] = a & b;
                    FN_OR:  r[ins[15:11]] = a | b;
                    FN_XOR: r[ins[15:11]] = a ^ b;
                    FN_NOR: r[ins[15:11]] = ~(a | b);
                    FN_SLT: r[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
                    default: ;
                endcase
            end
            OP_ADDI, OP_ADDIU: r[rt] = a + se;
            OP_ANDI: r[rt] = a & se;
            OP_ORI:  r[rt] = a | se;
            OP_SLTI: r[rt] = {31'd0, $signed(a) < $signed(se)};
            OP_SLTIU: r[rt] = {31'd0, a < se};
            OP_LW: begin
                r[rt] = refMem[addr[9:2]];
                expLoad.push_back(addr);
            end
            OP_SW: begin
                expAddr.push_back(addr);
                expData.push_back(b);
                refMem[addr[9:2]] = b;
                done = (addr == SENTINEL);
            end
            OP_BEQ: if (a == b) pc = pc + (se << 2);
            OP_BNE: if (a != b) pc = pc + (se << 2);
            default: ;
        endcase
        r[0] = '0;
        steps++;
    end
endfunction

// ==== tbPipelineCore.sv ====
module tbPipelineCore;
    import isaPkg::*;
    import corePkg::*;

    localparam logic [XLEN-1:0] SENTINEL = 32'h0000_03fc;

    logic            iClk;
    logic            iRst_n;
    logic [XLEN-1:0] instAddr;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] memAddr;
    logic [XLEN-1:0] memWrData;
    logic            memWrite;
    logic            memRead;
    logic [XLEN-1:0] memRdData;

    // Word-addressed models, 1 KiB each
    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [256];
    logic [XLEN-1:0] refMem [256];
    logic [31:0]     lcgState;
    int              progLen;
    int              storeIdx;
    logic [XLEN-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];
    logic [XLEN-1:0] expLoad [$];

    `include "tbProgram.svh"

    pipelineCore uut (
        .iClk      (iClk),
        .iRst_n    (iRst_n),
        .instAddr  (instAddr),
        .inst      (inst),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .memRdData (memRdData)
    );

    // Outside the program window the core sees no-ops
    assign inst = (instAddr[31:10] == RESET_PC[31:10]) ? imem[instAddr[9:2]] : '0;
    assign memRdData = dmem[memAddr[9:2]];

    initial begin
        iClk = 1'b0;
        forever begin
            #10 iClk = ~iClk;
        end
    end

    initial begin
        iRst_n   = 1'b0;
        lcgState = 32'hd450_a165;
        progLen  = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = nextRand();
        end
        buildProgram();
        runReference();
        repeat (4) @(posedge iClk);
        #2;
        // Core leaves reset idle at the first fetch address
        assert (instAddr == RESET_PC && !memWrite && !memRead) else begin
            $display("ERR %0t reset state: instAddr %h memWrite %b memRead %b",
                     $time, instAddr, memWrite, memRead);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        iRst_n = 1'b1;
    end

    always @(posedge iClk) begin
        if (memWrite) begin
            dmem[memAddr[9:2]] <= memWrData;
        end
    end

    // Compare each load and store with the next expected access
    always @(posedge iClk) begin
        if (iRst_n && memRead) begin
            assert (expLoad.size() != 0) else begin
                $display("Load from %h arrived after all expected loads", memAddr);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            assert (memAddr == expLoad[0]) else begin
                $display("ERR %0t load mismatch: addr %h, expected addr %h",
                         $time, memAddr, expLoad[0]);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            void'(expLoad.pop_front());
        end
        if (iRst_n && memWrite) begin
            assert (expAddr.size() != 0) else begin
                $display("Store to %h arrived after all expected stores", memAddr);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            assert (memAddr == expAddr[0] && memWrData == expData[0]) else begin
                $display("ERR %0t store mismatch: addr %h data %h, expected addr %h data %h",
                         $time, memAddr, memWrData, expAddr[0], expData[0]);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            if (memAddr == SENTINEL) begin
                if (expAddr.size() == 0 && expLoad.size() == 0) begin
                    $display("TESTBENCH PASSED");
                    $finish;
                end else begin
                    $display("Sentinel store came with %0d stores and %0d loads still missing",
                             expAddr.size(), expLoad.size());
                    $display("TESTBENCH FAILED");
                    $fatal(1);
                end
            end
        end
    end

    // Four cycles per instruction covers stalls and redirects
    initial begin
        wait (progLen > 0);
        repeat (progLen * 4 + 100) @(posedge iClk);
        $display("Timeout: the sentinel store never came");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== pipelineCore.f ====
+incdir+.
isaPkg.sv
corePkg.sv
fetchStage.sv
regFile.sv
decodeCtrl.sv
aluUnit.sv
hazardUnit.sv
execStage.sv
memWbStage.sv
pipelineCore.sv
tbPipelineCore.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tbPipelineCore -f pipelineCore.f

sim:
	verilator --binary --timing --top-module tbPipelineCore -f pipelineCore.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
